/* flist.f */
rtl/core_pkg.sv
rtl/fetch_buffer.sv
rtl/inst_decode.sv
rtl/issue_stage.sv
rtl/reg_file.sv
rtl/alu_pipe.sv
rtl/core.sv
verif/tb_core.sv

/* Makefile */
SRCS := $(shell cat flist.f)

.PHONY: all run clean

all: run

obj_dir/Vtb_core: flist.f $(SRCS)
	verilator --binary --timing --timescale 1ns/1ps --top-module tb_core -f flist.f

run: obj_dir/Vtb_core
	@out="$$(./obj_dir/Vtb_core)"; echo "$$out"; echo "$$out" | grep -qx 'RESULT: PASS'

clean:
	rm -rf obj_dir

/* verif/tb_core.sv */
/*
 * testbench for the integer core
 * random ALU programs, in-order reference model, credit tracking, timeout
 */
`default_nettype none

module tb_core;
  timeunit 1ns;
  timeprecision 1ps;

  import core_pkg::*;

  localparam int N_RANDOM       = 40;
  localparam int N_CHAIN        = 20;
  localparam int N_X0           = 16;
  localparam int N_BURST        = 24;
  localparam int NUM_INST       = N_RANDOM + N_CHAIN + N_X0 + N_BURST;
  localparam int TIMEOUT_CYCLES = 20 * NUM_INST + 200;

  logic          clock;
  logic          reset;
  logic          inst_valid;
  fetch_packet_t inst;
  logic          credit;
  writeback_t    wb;

  int            seed = 32'h282d_60ef;
  credit_cnt_t   credits;
  pc_t           next_pc;
  word_t         model_regs [NUM_REGS];
  writeback_t    expected_q [$];
  string         exp_name_q [$];
  int            exp_total;
  int            wb_seen;
  int            value_errors;
  int            other_errors;
  int            cycles;

  core i_dut (
    .clock      (clock),
    .reset      (reset),
    .inst_valid (inst_valid),
    .inst       (inst),
    .credit     (credit),
    .wb         (wb)
  );

  initial begin
    clock = 1'b0;
    forever #20 clock = ~clock;
  end

  function automatic int rand_range(input int n);
    return int'($unsigned($random(seed)) % n);
  endfunction

  task automatic check_wb(input string name, input writeback_t want, input writeback_t got);
    if (got !== want) begin
      value_errors++;
      $display("[FAIL] %s: expected v%0b x%0d=%h pc %h, actual v%0b x%0d=%h pc %h", name,
               want.valid, want.rd, want.data, want.pc, got.valid, got.rd, got.data, got.pc);
    end
  endtask

  task automatic check_credits(input string name, input credit_cnt_t want,
                               input credit_cnt_t got);
    if (got !== want) begin
      value_errors++;
      $display("[FAIL] %s: expected %0d credits, actual %0d", name, want, got);
    end
  endtask

  task automatic check_idle(input string name);
    if (credit !== 1'b0 || wb.valid !== 1'b0) begin
      other_errors++;
      $display("%s: credit or writeback valid is high while the core should be idle", name);
    end
  endtask

  // one clock then collect any returned credit
  task automatic tick();
    @(posedge clock);
    #2;
    inst_valid = 1'b0;
    if (credit === 1'b1) begin
      if (credits == credit_cnt_t'(FB_DEPTH)) begin
        other_errors++;
        $display("a credit came back while the sender already held all of them");
      end else begin
        credits = credits + 1'b1;
      end
    end
  endtask

  task automatic send_packet(input inst_t w, input int gap);
    tick();
    repeat (gap) tick();
    while (credits == '0) tick();
    inst_valid = 1'b1;
    inst.pc    = next_pc;
    inst.inst  = w;
    next_pc    = next_pc + 32'd4;
    credits    = credits - 1'b1;
  endtask

  // encode per RV32I and execute on the model registers
  task automatic send_op(input string name, input int gap, input alu_op_e op,
                         input logic use_imm, input reg_idx_t rd, input reg_idx_t rs1,
                         input reg_idx_t rs2, input logic [11:0] imm);
    logic [2:0] f3;
    logic [6:0] f7;
    inst_t      w;
    word_t      a;
    word_t      b;
    word_t      r;
    writeback_t e;
    case (op)
      ALU_AND: f3 = 3'b111;
      ALU_OR:  f3 = 3'b110;
      ALU_XOR: f3 = 3'b100;
      ALU_SLT: f3 = 3'b010;
      default: f3 = 3'b000;
    endcase
    f7 = (op == ALU_SUB) ? 7'b0100000 : 7'b0000000;
    w  = use_imm ? {imm, rs1, f3, rd, 7'b0010011} : {f7, rs2, rs1, f3, rd, 7'b0110011};
    a  = model_regs[rs1];
    b  = use_imm ? {{20{imm[11]}}, imm} : model_regs[rs2];
    case (op)
      ALU_ADD: r = a + b;
      ALU_SUB: r = a - b;
      ALU_AND: r = a & b;
      ALU_OR:  r = a | b;
      ALU_XOR: r = a ^ b;
      ALU_SLT: r = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
      default: r = '0;
    endcase
    if (rd != 5'd0) begin
      model_regs[rd] = r;
      e.valid = 1'b1;
      e.rd    = rd;
      e.data  = r;
      e.pc    = next_pc;
      expected_q.push_back(e);
      exp_name_q.push_back(name);
      exp_total++;
    end
    send_packet(w, gap);
  endtask

  task automatic send_random(input string name, input int gap, input reg_idx_t rd,
                             input reg_idx_t rs1, input reg_idx_t rs2);
    alu_op_e     op;
    logic        use_imm;
    logic [11:0] imm;
    op      = alu_op_e'(rand_range(6));
    use_imm = (rand_range(2) == 1) && (op != ALU_SUB);
    imm     = 12'($random(seed));
    send_op(name, gap, op, use_imm, rd, rs1, rs2, imm);
  endtask

  // encodings outside the supported subset
  function automatic inst_t illegal_inst(input int sel, input reg_idx_t rd);
    case (sel)
      0:       return {12'h004, 5'd1, 3'b000, rd, 7'b0000011};
      1:       return {7'b0100000, 5'd2, 5'd3, 3'b111, rd, 7'b0110011};
      2:       return {7'b0000000, 5'd2, 5'd3, 3'b001, rd, 7'b0110011};
      default: return {12'h005, 5'd4, 3'b011, rd, 7'b0010011};
    endcase
  endfunction

  always @(negedge clock) begin : wb_monitor
    writeback_t want;
    string      name;
    if (wb.valid === 1'b1) begin
      wb_seen++;
      if (expected_q.size() == 0) begin
        other_errors++;
        $display("unexpected writeback to x%0d from pc %h", wb.rd, wb.pc);
      end else begin
        want = expected_q.pop_front();
        name = exp_name_q.pop_front();
        check_wb(name, want, wb);
      end
    end
  end

  initial begin : watchdog
    cycles = 0;
    while (cycles < TIMEOUT_CYCLES) begin
      @(posedge clock);
      cycles++;
    end
    $display("timeout after %0d cycles, %0d writebacks still missing", cycles,
             expected_q.size());
    $display("RESULT: FAIL");
    $finish;
  end

  initial begin : stimulus
    reg_idx_t prev_rd;
    reg_idx_t rd;
    reset        = 1'b1;
    inst_valid   = 1'b0;
    inst         = '0;
    credits      = '0;
    next_pc      = 32'h0000_1000;
    exp_total    = 0;
    wb_seen      = 0;
    value_errors = 0;
    other_errors = 0;
    foreach (model_regs[k]) model_regs[k] = '0;

    repeat (8) begin
      @(posedge clock);
      #2;
      check_idle("reset");
    end
    reset   = 1'b0;
    credits = credit_cnt_t'(FB_DEPTH);
    tick();
    check_idle("after_reset");

    for (int i = 0; i < N_RANDOM; i++) begin
      send_random("random_ops", rand_range(4), reg_idx_t'(1 + rand_range(31)),
                  reg_idx_t'(rand_range(32)), reg_idx_t'(rand_range(32)));
    end

    // each op reads the rd of the one before
    prev_rd = 5'd1;
    for (int i = 0; i < N_CHAIN; i++) begin
      rd = reg_idx_t'(1 + rand_range(31));
      send_random("chain", 0, rd, prev_rd, prev_rd);
      prev_rd = rd;
    end

    for (int i = 0; i < N_X0; i++) begin
      case (i % 4)
        0: send_random("x0_dest", rand_range(3), 5'd0, reg_idx_t'(rand_range(32)),
                       reg_idx_t'(rand_range(32)));
        2: send_random("x0_read", rand_range(3), reg_idx_t'(1 + rand_range(31)), 5'd0, 5'd0);
        default: send_packet(illegal_inst(rand_range(4), reg_idx_t'(1 + rand_range(31))),
                             rand_range(3));
      endcase
    end

    for (int i = 0; i < N_BURST; i++) begin
      send_random("burst", 0, reg_idx_t'(1 + rand_range(31)), reg_idx_t'(rand_range(32)),
                  reg_idx_t'(rand_range(32)));
    end

    // drain then watch a while for stray results or credits
    while (expected_q.size() != 0) tick();
    repeat (10) tick();
    check_credits("drain", credit_cnt_t'(FB_DEPTH), credits);
    if (wb_seen != exp_total) begin
      other_errors++;
      $display("saw %0d writebacks but the model expected %0d", wb_seen, exp_total);
    end

    $display("errors: %0d value mismatches, %0d other failures", value_errors, other_errors);
    if (value_errors == 0 && other_errors == 0) begin
      $display("RESULT: PASS");
    end else begin
      $display("RESULT: FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* rtl/core.sv */
/*
 * integer core top level
 * fetch buffer, decode, issue, register file and ALU pipe
 */
`default_nettype none

module core (
  input  wire                     clock,
  input  wire                     reset,
  input  wire                     inst_valid,
  input  core_pkg::fetch_packet_t inst,
  output logic                    credit,
  output core_pkg::writeback_t    wb
);

  import core_pkg::*;

  fetch_packet_t head;
  logic          head_valid;
  logic          pop;
  micro_op_t     id_uop;
  logic          issue_ready;
  reg_idx_t      rs1_addr;
  reg_idx_t      rs2_addr;
  word_t         rs1_data;
  word_t         rs2_data;
  micro_op_t     ex_uop;
  word_t         ex_rs1_data;
  word_t         ex_rs2_data;
  writeback_t    wb_result;

  fetch_buffer fb (
    .clock      (clock),
    .reset      (reset),
    .push       (inst_valid),
    .push_data  (inst),
    .pop        (pop),
    .head       (head),
    .head_valid (head_valid),
    .credit     (credit)
  );

  inst_decode id (
    .clock       (clock),
    .reset       (reset),
    .head        (head),
    .head_valid  (head_valid),
    .issue_ready (issue_ready),
    .pop         (pop),
    .id_uop      (id_uop)
  );

  issue_stage is0 (
    .clock       (clock),
    .reset       (reset),
    .id_uop      (id_uop),
    .wb_result   (wb_result),
    .rs1_addr    (rs1_addr),
    .rs2_addr    (rs2_addr),
    .rs1_data    (rs1_data),
    .rs2_data    (rs2_data),
    .issue_ready (issue_ready),
    .ex_uop      (ex_uop),
    .ex_rs1_data (ex_rs1_data),
    .ex_rs2_data (ex_rs2_data)
  );

  reg_file rf (
    .clock     (clock),
    .reset     (reset),
    .rs1_addr  (rs1_addr),
    .rs2_addr  (rs2_addr),
    .rs1_data  (rs1_data),
    .rs2_data  (rs2_data),
    .wb_result (wb_result)
  );

  alu_pipe alu (
    .clock       (clock),
    .reset       (reset),
    .ex_uop      (ex_uop),
    .ex_rs1_data (ex_rs1_data),
    .ex_rs2_data (ex_rs2_data),
    .wb_result   (wb_result)
  );

  assign wb = wb_result;

endmodule

`default_nettype wire

/* rtl/alu_pipe.sv */
/*
 * single-cycle integer ALU pipe
 * add, sub, and, or, xor, signed slt, registered writeback
 */
`default_nettype none

module alu_pipe (
  input  wire                  clock,
  input  wire                  reset,
  input  core_pkg::micro_op_t  ex_uop,
  input  core_pkg::word_t      ex_rs1_data,
  input  core_pkg::word_t      ex_rs2_data,
  output core_pkg::writeback_t wb_result
);

  import core_pkg::*;

  word_t op_a;
  word_t op_b;
  word_t result;

  assign op_a = ex_rs1_data;
  assign op_b = ex_uop.use_imm ? ex_uop.imm : ex_rs2_data;

  always_comb begin
    case (ex_uop.alu_op)
      ALU_ADD: result = op_a + op_b;
      ALU_SUB: result = op_a - op_b;
      ALU_AND: result = op_a & op_b;
      ALU_OR:  result = op_a | op_b;
      ALU_XOR: result = op_a ^ op_b;
      ALU_SLT: result = ($signed(op_a) < $signed(op_b)) ? word_t'(1) : '0;
      default: result = '0;
    endcase
  end

  // only ops with a real destination reach writeback
  always_ff @(posedge clock) begin
    if (reset) begin
      wb_result.valid <= 1'b0;
    end else begin
      wb_result.valid <= ex_uop.valid && ex_uop.rd_valid;
    end
  end

  always_ff @(posedge clock) begin
    wb_result.rd   <= ex_uop.rd;
    wb_result.data <= result;
    wb_result.pc   <= ex_uop.pc;
  end

endmodule

`default_nettype wire

/* rtl/reg_file.sv */
/*
 * integer register file, 32 x 32
 * two combinational reads, one write from writeback
 */
`default_nettype none

module reg_file (
  input  wire                  clock,
  input  wire                  reset,
  input  core_pkg::reg_idx_t   rs1_addr,
  input  core_pkg::reg_idx_t   rs2_addr,
  output core_pkg::word_t      rs1_data,
  output core_pkg::word_t      rs2_data,
  input  core_pkg::writeback_t wb_result
);

  import core_pkg::*;

  word_t regs [NUM_REGS];

  assign rs1_data = (rs1_addr == '0) ? '0 : regs[rs1_addr];
  assign rs2_data = (rs2_addr == '0) ? '0 : regs[rs2_addr];

  always_ff @(posedge clock) begin
    if (reset) begin
      for (int i = 0; i < NUM_REGS; i++) begin
        regs[i] <= '0;
      end
    end else if (wb_result.valid) begin
      regs[wb_result.rd] <= wb_result.data;
    end
  end

endmodule

`default_nettype wire

/* rtl/issue_stage.sv */
/*
 * in-order issue with a busy-register scoreboard
 * operand read and execute pipeline register
 */
`default_nettype none

module issue_stage (
  input  wire                  clock,
  input  wire                  reset,
  input  core_pkg::micro_op_t  id_uop,
  input  core_pkg::writeback_t wb_result,
  output core_pkg::reg_idx_t   rs1_addr,
  output core_pkg::reg_idx_t   rs2_addr,
  input  core_pkg::word_t      rs1_data,
  input  core_pkg::word_t      rs2_data,
  output logic                 issue_ready,
  output core_pkg::micro_op_t  ex_uop,
  output core_pkg::word_t      ex_rs1_data,
  output core_pkg::word_t      ex_rs2_data
);

  import core_pkg::*;

  logic [NUM_REGS-1:0] busy;
  logic [NUM_REGS-1:0] busy_next;
  logic                hazard;
  logic                issue;

  assign rs1_addr = id_uop.rs1;
  assign rs2_addr = id_uop.rs2;

  // x0 is never marked busy
  assign hazard = busy[id_uop.rs1] || busy[id_uop.rs2] ||
                  (id_uop.rd_valid && busy[id_uop.rd]);

  // illegal ops drain without issuing
  assign issue_ready = !id_uop.valid || !hazard;
  assign issue       = id_uop.valid && !hazard;

  always_comb begin
    busy_next = busy;
    if (wb_result.valid) begin
      busy_next[wb_result.rd] = 1'b0;
    end
    if (issue && id_uop.rd_valid) begin
      busy_next[id_uop.rd] = 1'b1;
    end
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      busy   <= '0;
      ex_uop <= '0;
    end else begin
      busy         <= busy_next;
      ex_uop       <= id_uop;
      ex_uop.valid <= issue;
    end
  end

  always_ff @(posedge clock) begin
    ex_rs1_data <= rs1_data;
    ex_rs2_data <= rs2_data;
  end

endmodule

`default_nettype wire

/* rtl/inst_decode.sv */
/*
 * decode stage for the RV32I ALU subset
 * register and immediate forms, decode pipeline register
 */
`default_nettype none

module inst_decode (
  input  wire                     clock,
  input  wire                     reset,
  input  core_pkg::fetch_packet_t head,
  input  wire                     head_valid,
  input  wire                     issue_ready,
  output logic                    pop,
  output core_pkg::micro_op_t     id_uop
);

  import core_pkg::*;

  logic load;

  function automatic micro_op_t decode_inst(input fetch_packet_t pkt);
    micro_op_t  uop;
    logic [6:0] opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;
    logic       legal;
    opcode     = pkt.inst[6:0];
    funct3     = pkt.inst[14:12];
    funct7     = pkt.inst[31:25];
    uop        = '0;
    uop.pc     = pkt.pc;
    uop.rs1    = pkt.inst[19:15];
    uop.rd     = pkt.inst[11:7];
    uop.imm    = {{20{pkt.inst[31]}}, pkt.inst[31:20]};
    uop.alu_op = ALU_ADD;
    legal      = 1'b0;
    case (opcode)
      OPC_OP: begin
        uop.rs2 = pkt.inst[24:20];
        legal   = (funct7 == 7'b0) || (funct7 == F7_SUB && funct3 == 3'b000);
        case (funct3)
          3'b000:  uop.alu_op = (funct7 == F7_SUB) ? ALU_SUB : ALU_ADD;
          3'b010:  uop.alu_op = ALU_SLT;
          3'b100:  uop.alu_op = ALU_XOR;
          3'b110:  uop.alu_op = ALU_OR;
          3'b111:  uop.alu_op = ALU_AND;
          default: legal = 1'b0;
        endcase
      end
      OPC_OP_IMM: begin
        // rs2 stays x0 so it never looks busy
        uop.use_imm = 1'b1;
        legal       = 1'b1;
        case (funct3)
          3'b000:  uop.alu_op = ALU_ADD;
          3'b010:  uop.alu_op = ALU_SLT;
          3'b100:  uop.alu_op = ALU_XOR;
          3'b110:  uop.alu_op = ALU_OR;
          3'b111:  uop.alu_op = ALU_AND;
          default: legal = 1'b0;
        endcase
      end
      default: legal = 1'b0;
    endcase
    uop.valid    = legal;
    uop.rd_valid = legal && (uop.rd != '0);
    return uop;
  endfunction

  // empty or draining register takes the next packet
  assign load = !id_uop.valid || issue_ready;
  assign pop  = load && head_valid;

  always_ff @(posedge clock) begin
    if (reset) begin
      id_uop <= '0;
    end else if (load) begin
      id_uop <= head_valid ? decode_inst(head) : '0;
    end
  end

endmodule

`default_nettype wire

/* rtl/fetch_buffer.sv */
/*
 * fetch packet FIFO in front of decode
 * returns one credit to the sender for every entry popped
 */
`default_nettype none

module fetch_buffer (
  input  wire                   clock,
  input  wire                   reset,
  input  wire                   push,
  input  core_pkg::fetch_packet_t push_data,
  input  wire                   pop,
  output core_pkg::fetch_packet_t head,
  output logic                  head_valid,
  output logic                  credit
);

  import core_pkg::*;

  fetch_packet_t mem [FB_DEPTH];
  fb_ptr_t       wr_ptr;
  fb_ptr_t       rd_ptr;
  credit_cnt_t   count;
  logic          pop_ok;

  assign head_valid = (count != '0);
  assign head       = mem[rd_ptr];
  assign pop_ok     = pop && head_valid;

  // entry storage
  always_ff @(posedge clock) begin
    if (push) begin
      mem[wr_ptr] <= push_data;
    end
  end

  // pointers wrap since depth is a power of two
  always_ff @(posedge clock) begin
    if (reset) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
      credit <= 1'b0;
    end else begin
      if (push) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (pop_ok) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      count  <= count + credit_cnt_t'(push) - credit_cnt_t'(pop_ok);
      credit <= pop_ok;
    end
  end

endmodule

`default_nettype wire

/* rtl/core_pkg.sv */
/*
 * shared widths, types and constants for the integer core
 * ALU operation enum, fetch packet, micro-op and writeback structs
 */
`default_nettype none

package core_pkg;

  localparam int XLEN     = 32;
  localparam int NUM_REGS = 32;
  localparam int FB_DEPTH = 4;
  localparam int FB_PTR_W = $clog2(FB_DEPTH);

  // RV32I major opcodes handled here
  localparam logic [6:0] OPC_OP     = 7'b0110011;
  localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
  localparam logic [6:0] F7_SUB     = 7'b0100000;

  typedef logic [XLEN-1:0]     word_t;
  typedef logic [31:0]         inst_t;
  typedef logic [31:0]         pc_t;
  typedef logic [4:0]          reg_idx_t;
  typedef logic [2:0]          credit_cnt_t;
  typedef logic [FB_PTR_W-1:0] fb_ptr_t;

  typedef enum logic [2:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_AND,
    ALU_OR,
    ALU_XOR,
    ALU_SLT
  } alu_op_e;

  typedef struct packed {
    pc_t   pc;
    inst_t inst;
  } fetch_packet_t;

  typedef struct packed {
    pc_t      pc;
    alu_op_e  alu_op;
    reg_idx_t rs1;
    reg_idx_t rs2;
    reg_idx_t rd;
    word_t    imm;
    logic     use_imm;
    logic     rd_valid;  // writes a non-zero rd
    logic     valid;
  } micro_op_t;

  typedef struct packed {
    logic     valid;
    reg_idx_t rd;
    word_t    data;
    pc_t      pc;
  } writeback_t;

endpackage

`default_nettype wire
